//--- divCfgPkg.sv
/* divider configuration constants
   operand width, iteration count and counter width */

`default_nettype none

package divCfgPkg;

	// ============================================================
	// datapath sizing
	// ============================================================

	// dividend, divisor, quotient and remainder all share this width
	localparam int divWidth = 28;

	// ============================================================
	// sequencing
	// ============================================================

	// one quotient bit per clock, so one cycle per operand bit
	localparam int divIters = divWidth;

	// iteration counter must be able to hold divIters
	localparam int divCntWidth = 5;

endpackage : divCfgPkg

`default_nettype wire

//--- divTypesPkg.sv
/* divider type definitions
   controller state encoding and operand signedness mode */

`default_nettype none

package divTypesPkg;

	// ============================================================
	// controller states
	// ============================================================

	// Idle     waiting for ld
	// Iterate  one shift-subtract step per clock
	// Finish   sign fix and output write, one clock
	typedef enum logic [1:0] {
		Idle    = 2'd0,
		Iterate = 2'd1,
		Finish  = 2'd2
	} divState;

	// ============================================================
	// operand interpretation
	// ============================================================

	// decoded from sgn and sgnus, sgn wins when both are set
	typedef enum logic [1:0] {
		Unsigned         = 2'd0,
		Signed           = 2'd1,
		SignedByUnsigned = 2'd2
	} divMode;

endpackage : divTypesPkg

`default_nettype wire

//--- divCtrl.sv
/* divider sequencing FSM
   iteration counter, abort handling, done pulse and idle level */

`timescale 1ns/1ps
`default_nettype none

module divCtrl (
	input  logic clk,
	input  logic rst,
	input  logic ld,
	input  logic abort,
	output logic loadEn,
	output logic iterEn,
	output logic finishEn,
	output logic done,
	output logic idle
);
	import divCfgPkg::*;
	import divTypesPkg::*;

	divState state;
	logic [divCntWidth-1:0] cnt;
	logic lastIter;

	// ============================================================
	// enables and status
	// ============================================================

	// counter reaches zero on this edge
	assign lastIter = (cnt == divCntWidth'(1));

	assign idle = (state == Idle);

	// a load in the done cycle is ignored, the result is still being presented
	assign loadEn = idle && ld && !done;

	// abort suppresses the step and the output write in the same cycle
	assign iterEn = (state == Iterate) && !abort;
	assign finishEn = (state == Finish) && !abort;

	// ============================================================
	// state register and down-counter
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			// done follows a completed finish by one clock
			done <= finishEn;
			case (state)
				Idle: begin
					if (loadEn) begin
						state <= Iterate;
						cnt <= divCntWidth'(divIters);
					end
				end
				Iterate: begin
					if (abort) begin
						state <= Idle;
					end else begin
						cnt <= cnt - 1'b1;
						if (lastIter) begin
							state <= Finish;
						end
					end
				end
				Finish: begin
					// abort or not, finish always drops back to idle
					state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// no new operation starts in the cycle that shows a result
	aLoadNotAtDone: assert property (@(posedge clk) disable iff (rst)
		loadEn |-> !$past(finishEn));

	aFinishOneCycle: assert property (@(posedge clk) disable iff (rst)
		finishEn |=> !finishEn);

	aAbortToIdle: assert property (@(posedge clk) disable iff (rst)
		(state == Iterate && abort) |=> idle && !done);

endmodule : divCtrl

`default_nettype wire

//--- divOperandPrep.sv
/* operand preparation for the divider
   mode decode, magnitudes, result sign flags and zero-divisor flag */

`timescale 1ns/1ps
`default_nettype none

module divOperandPrep (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       loadEn,
	input  logic                       sgn,
	input  logic                       sgnus,
	input  logic [divCfgPkg::divWidth-1:0] a,
	input  logic [divCfgPkg::divWidth-1:0] b,
	output logic [divCfgPkg::divWidth-1:0] absA,
	output logic [divCfgPkg::divWidth-1:0] absB,
	output logic                       negQ,
	output logic                       negR,
	output logic                       dvByZr
);
	import divCfgPkg::*;
	import divTypesPkg::*;

	divMode mode;
	logic signA;
	logic signB;
	logic qSign;
	logic rSign;

	// sgn has priority over sgnus
	assign mode = sgn ? Signed : (sgnus ? SignedByUnsigned : Unsigned);

	assign signA = a[divWidth-1];
	assign signB = b[divWidth-1];

	// magnitudes and result signs per mode
	always_comb begin
		absA = a;
		absB = b;
		qSign = 1'b0;
		rSign = 1'b0;
		case (mode)
			Signed: begin
				absA = signA ? -a : a;
				absB = signB ? -b : b;
				qSign = signA ^ signB;
				rSign = signA;
			end
			SignedByUnsigned: begin
				// divisor stays an unsigned magnitude
				absA = signA ? -a : a;
				qSign = signA;
				rSign = signA;
			end
			default: begin
			end
		endcase
	end

	// flags captured with the operands, held through the iteration
	always_ff @(posedge clk) begin
		if (rst) begin
			negQ <= 1'b0;
			negR <= 1'b0;
			dvByZr <= 1'b0;
		end else if (loadEn) begin
			negQ <= qSign;
			negR <= rSign;
			dvByZr <= (b == '0);
		end
	end

endmodule : divOperandPrep

`default_nettype wire

//--- divCore.sv
/* restoring shift-subtract divider datapath
   partial quotient and partial remainder registers */

`timescale 1ns/1ps
`default_nettype none

module divCore (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       loadEn,
	input  logic                       iterEn,
	input  logic [divCfgPkg::divWidth-1:0] absA,
	input  logic [divCfgPkg::divWidth-1:0] absB,
	output logic [divCfgPkg::divWidth-1:0] q,
	output logic [divCfgPkg::divWidth-1:0] r
);
	import divCfgPkg::*;

	logic [divWidth-1:0] divisor;
	logic [divWidth:0] rShift;
	logic [divWidth:0] rDiff;
	logic fits;

	// ============================================================
	// one step: bring in next dividend bit, trial subtract
	// ============================================================

	// remainder shifted left with the dividend msb from q
	assign rShift = {r, q[divWidth-1]};
	assign rDiff = rShift - {1'b0, divisor};

	// divisor fits, so this quotient bit is one
	assign fits = (rShift >= {1'b0, divisor});

	// ============================================================
	// registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (loadEn) begin
			q <= absA;
			r <= '0;
			divisor <= absB;
		end else if (iterEn) begin
			// dividend bits leave the top as quotient bits enter the bottom
			q <= {q[divWidth-2:0], fits};
			// the kept remainder is always below the divisor and fits divWidth bits
			r <= fits ? rDiff[divWidth-1:0] : rShift[divWidth-1:0];
		end
	end

	aLoadIterExcl: assert property (@(posedge clk) disable iff (rst)
		!(loadEn && iterEn));

endmodule : divCore

`default_nettype wire

//--- divResultFix.sv
/* divider result stage
   sign correction and registered quotient and remainder */

`timescale 1ns/1ps
`default_nettype none

module divResultFix (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       finishEn,
	input  logic                       negQ,
	input  logic                       negR,
	input  logic [divCfgPkg::divWidth-1:0] q,
	input  logic [divCfgPkg::divWidth-1:0] r,
	output logic [divCfgPkg::divWidth-1:0] qo,
	output logic [divCfgPkg::divWidth-1:0] ro
);
	import divCfgPkg::*;

	logic [divWidth-1:0] qFix;
	logic [divWidth-1:0] rFix;

	// ============================================================
	// sign correction
	// ============================================================

	// truncating divide: quotient by the combined sign
	assign qFix = negQ ? -q : q;

	// remainder follows the dividend sign only
	assign rFix = negR ? -r : r;

	// ============================================================
	// output registers
	// ============================================================

	// written only at finish, held otherwise, so an abort leaves the old result
	always_ff @(posedge clk) begin
		if (rst) begin
			qo <= '0;
			ro <= '0;
		end else if (finishEn) begin
			qo <= qFix;
			ro <= rFix;
		end
	end

endmodule : divResultFix

`default_nettype wire

//--- divUnit.sv
/* iterative integer divide unit top level
   controller, operand prep, shift-subtract core and result stage */

`timescale 1ns/1ps
`default_nettype none

module divUnit (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ld,
	input  logic                       abort,
	input  logic                       sgn,
	input  logic                       sgnus,
	input  logic [divCfgPkg::divWidth-1:0] a,
	input  logic [divCfgPkg::divWidth-1:0] b,
	output logic [divCfgPkg::divWidth-1:0] qo,
	output logic [divCfgPkg::divWidth-1:0] ro,
	output logic                       dvByZr,
	output logic                       done,
	output logic                       idle
);
	import divCfgPkg::*;

	// ============================================================
	// internal nets
	// ============================================================

	// sequencing enables
	logic loadEn;
	logic iterEn;
	logic finishEn;

	// operand magnitudes into the core
	logic [divWidth-1:0] absA;
	logic [divWidth-1:0] absB;

	// result sign flags
	logic negQ;
	logic negR;

	// unsigned quotient and remainder from the core
	logic [divWidth-1:0] q;
	logic [divWidth-1:0] r;

	// ============================================================
	// instances
	// ============================================================

	divCtrl i_ctrl (
		.clk      (clk),
		.rst      (rst),
		.ld       (ld),
		.abort    (abort),
		.loadEn   (loadEn),
		.iterEn   (iterEn),
		.finishEn (finishEn),
		.done     (done),
		.idle     (idle)
	);

	divOperandPrep i_prep (
		.clk    (clk),
		.rst    (rst),
		.loadEn (loadEn),
		.sgn    (sgn),
		.sgnus  (sgnus),
		.a      (a),
		.b      (b),
		.absA   (absA),
		.absB   (absB),
		.negQ   (negQ),
		.negR   (negR),
		.dvByZr (dvByZr)
	);

	divCore i_core (
		.clk    (clk),
		.rst    (rst),
		.loadEn (loadEn),
		.iterEn (iterEn),
		.absA   (absA),
		.absB   (absB),
		.q      (q),
		.r      (r)
	);

	divResultFix i_fix (
		.clk      (clk),
		.rst      (rst),
		.finishEn (finishEn),
		.negQ     (negQ),
		.negR     (negR),
		.q        (q),
		.r        (r),
		.qo       (qo),
		.ro       (ro)
	);

endmodule : divUnit

`default_nettype wire

//--- divUnitTb.sv
/* testbench for the iterative divide unit
   reference model, LCG and directed stimulus, concurrent checks */

`timescale 1ns/1ps
`default_nettype none

module divUnitTb;
	import divCfgPkg::*;
	import divTypesPkg::*;

	localparam int resetCycles = 8;
	localparam int numRandom = 32;
	// directed runs, the busy-load run and the two runs after an abort
	localparam int numDirected = 18;
	localparam int numAborts = 2;
	// an operation takes at most divIters+4 clocks
	// an abort run takes about twice that
	localparam int cycleLimit = (numRandom + numDirected) * (divIters + 4)
		+ numAborts * 2 * (divIters + 4) + resetCycles + 16;
	localparam logic [divWidth-1:0] mostNeg = {1'b1, {(divWidth - 1){1'b0}}};

	logic clk = 1'b0;
	logic rst;
	logic ld;
	logic abort;
	logic sgn;
	logic sgnus;
	logic [divWidth-1:0] a;
	logic [divWidth-1:0] b;
	logic [divWidth-1:0] qo;
	logic [divWidth-1:0] ro;
	logic dvByZr;
	logic done;
	logic idle;

	// model results for the operation in flight
	logic [divWidth-1:0] expQ;
	logic [divWidth-1:0] expR;
	logic expZ;
	// set while an operation is started that will be aborted
	logic abortRun;
	string testName;
	logic [31:0] lcgState;
	int cycles = 0;
	int valueErrs = 0;
	int timingErrs = 0;
	int abortErrs = 0;
	int resetErrs = 0;

	always #10 clk = ~clk;

	divUnit i_dut (
		.clk    (clk),
		.rst    (rst),
		.ld     (ld),
		.abort  (abort),
		.sgn    (sgn),
		.sgnus  (sgnus),
		.a      (a),
		.b      (b),
		.qo     (qo),
		.ro     (ro),
		.dvByZr (dvByZr),
		.done   (done),
		.idle   (idle)
	);

	// ============================================================
	// reference model and random source
	// ============================================================

	// truncating divide with the remainder carrying the dividend sign
	task automatic modelDiv(input logic s, input logic su, input logic [divWidth-1:0] x,
			input logic [divWidth-1:0] y, output logic [divWidth-1:0] mq,
			output logic [divWidth-1:0] mr, output logic mz);
		divMode m;
		logic [divWidth-1:0] ma;
		logic [divWidth-1:0] mb;
		logic nq;
		logic nr;
		m = s ? Signed : (su ? SignedByUnsigned : Unsigned);
		ma = x;
		mb = y;
		nq = 1'b0;
		nr = 1'b0;
		if (m != Unsigned && x[divWidth-1]) begin
			ma = -x;
			nq = 1'b1;
			nr = 1'b1;
		end
		if (m == Signed && y[divWidth-1]) begin
			mb = -y;
			nq = !nq;
		end
		mz = (y == '0);
		// a zero divisor gives an all-ones magnitude and the dividend as remainder
		if (mz) begin
			mq = '1;
			mr = ma;
		end else begin
			mq = ma / mb;
			mr = ma % mb;
		end
		if (nq) mq = -mq;
		if (nr) mr = -mr;
	endtask

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// ============================================================
	// stimulus tasks
	// ============================================================

	task automatic driveLoad(input logic s, input logic su, input logic [divWidth-1:0] x,
			input logic [divWidth-1:0] y);
		ld <= 1'b1;
		sgn <= s;
		sgnus <= su;
		a <= x;
		b <= y;
	endtask

	// returns on the edge that samples done so expected values stay put there
	task automatic waitDone();
		@(negedge clk);
		while (!done) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic runOp(input string name, input logic s, input logic su,
			input logic [divWidth-1:0] x, input logic [divWidth-1:0] y);
		logic [divWidth-1:0] mq;
		logic [divWidth-1:0] mr;
		logic mz;
		modelDiv(s, su, x, y, mq, mr, mz);
		@(posedge clk);
		testName <= name;
		expQ <= mq;
		expR <= mr;
		expZ <= mz;
		driveLoad(s, su, x, y);
		@(posedge clk);
		ld <= 1'b0;
		waitDone();
	endtask

	// second ld mid-operation with other operands
	// it must be ignored
	task automatic runBusy(input string name, input logic [divWidth-1:0] x,
			input logic [divWidth-1:0] y);
		logic [divWidth-1:0] mq;
		logic [divWidth-1:0] mr;
		logic mz;
		modelDiv(1'b0, 1'b0, x, y, mq, mr, mz);
		@(posedge clk);
		testName <= name;
		expQ <= mq;
		expR <= mr;
		expZ <= mz;
		driveLoad(1'b0, 1'b0, x, y);
		@(posedge clk);
		ld <= 1'b0;
		repeat (6) @(posedge clk);
		driveLoad(1'b1, 1'b0, ~x, y + 1'b1);
		@(posedge clk);
		ld <= 1'b0;
		waitDone();
	endtask

	// abort k clocks after acceptance
	// k == divIters lands in Finish
	task automatic abortOp(input string name, input int k, input logic [divWidth-1:0] x,
			input logic [divWidth-1:0] y);
		@(posedge clk);
		testName <= name;
		abortRun <= 1'b1;
		driveLoad(1'b0, 1'b0, x, y);
		@(posedge clk);
		ld <= 1'b0;
		repeat (k) @(posedge clk);
		abort <= 1'b1;
		@(posedge clk);
		abort <= 1'b0;
		repeat (divIters + 3) @(posedge clk);
		abortRun <= 1'b0;
	endtask

	// ============================================================
	// checks
	// ============================================================

	aQuotient: assert property (@(posedge clk) disable iff (rst) done |-> qo == expQ)
		else begin
			valueErrs++;
			$display("** Error %s qo expected %h actual %h", testName, expQ, $sampled(qo));
		end

	aRemainder: assert property (@(posedge clk) disable iff (rst) done |-> ro == expR)
		else begin
			valueErrs++;
			$display("** Error %s ro expected %h actual %h", testName, expR, $sampled(ro));
		end

	aZeroFlag: assert property (@(posedge clk) disable iff (rst) done |-> dvByZr == expZ)
		else begin
			valueErrs++;
			$display("** Error %s dvByZr expected %b actual %b", testName, expZ,
				$sampled(dvByZr));
		end

	// idle stays low until done rises divIters+1 clocks after acceptance
	// done lasts one cycle
	aLatency: assert property (@(posedge clk) disable iff (rst)
		(ld && idle && !done && !abortRun) |=>
		(!done && !idle) [*(divIters + 1)] ##1 (done && idle) ##1 !done)
		else begin
			timingErrs++;
			$display("done or idle out of step after a load in test %s", testName);
		end

	aAbortIdle: assert property (@(posedge clk) disable iff (rst)
		(abort && !idle) |=> (idle && !done) ##1 (!done) [*divIters])
		else begin
			abortErrs++;
			$display("unit not idle or a done pulse appeared after abort in %s", testName);
		end

	// an aborted run leaves the previous operation's results in place
	aAbortHold: assert property (@(posedge clk) disable iff (rst)
		(abort && !idle) |=> qo == expQ && ro == expR && dvByZr == expZ)
		else begin
			abortErrs++;
			$display("** Error %s qo/ro/dvByZr expected %h/%h/%b actual %h/%h/%b",
				testName, expQ, expR, expZ, $sampled(qo), $sampled(ro),
				$sampled(dvByZr));
		end

	aResetState: assert property (@(posedge clk)
		$fell(rst) |-> idle && !done && qo == '0 && ro == '0 && !dvByZr)
		else begin
			resetErrs++;
			$display("outputs not in their reset state when reset was released");
		end

	// ============================================================
	// run limit and main sequence
	// ============================================================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("run stopped after %0d cycles, stuck in test %s", cycles, testName);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] rx;
		logic [31:0] ry;
		rst = 1'b1;
		ld = 1'b0;
		abort = 1'b0;
		sgn = 1'b0;
		sgnus = 1'b0;
		a = '0;
		b = '0;
		expQ = '0;
		expR = '0;
		expZ = 1'b0;
		abortRun = 1'b0;
		testName = "reset";
		lcgState = 32'd91;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;

		runOp("unsignedSmall", 1'b0, 1'b0, divWidth'(100), divWidth'(7));
		runOp("unsignedMax", 1'b0, 1'b0, '1, divWidth'(3));
		runOp("zeroUnsigned", 1'b0, 1'b0, divWidth'(1234567), '0);
		runOp("zeroSigned", 1'b1, 1'b0, -divWidth'(9), '0);
		// every sign pairing in signed mode
		runOp("signedPosPos", 1'b1, 1'b0, divWidth'(7), divWidth'(2));
		runOp("signedNegPos", 1'b1, 1'b0, -divWidth'(7), divWidth'(2));
		runOp("signedPosNeg", 1'b1, 1'b0, divWidth'(7), -divWidth'(2));
		runOp("signedNegNeg", 1'b1, 1'b0, -divWidth'(7), -divWidth'(2));
		runOp("signedMostNeg", 1'b1, 1'b0, mostNeg, divWidth'(3));
		runOp("signedMostNegByM1", 1'b1, 1'b0, mostNeg, -divWidth'(1));
		// divisor msb set is still a magnitude here
		runOp("sbuNegPos", 1'b0, 1'b1, -divWidth'(7), divWidth'(2));
		runOp("sbuPosPos", 1'b0, 1'b1, divWidth'(7), divWidth'(2));
		runOp("sbuBigDivisor", 1'b0, 1'b1, -divWidth'(100), divWidth'('hF000000));
		runOp("sbuMostNeg", 1'b0, 1'b1, mostNeg, divWidth'(5));
		runOp("bothModeBits", 1'b1, 1'b1, -divWidth'(7), -divWidth'(2));
		runBusy("ldWhileBusy", divWidth'(50000), divWidth'(13));

		abortOp("abortIterate", 5, divWidth'(999), divWidth'(4));
		runOp("afterAbortIterate", 1'b1, 1'b0, -divWidth'(1000), divWidth'(33));
		abortOp("abortFinish", divIters, divWidth'(77), divWidth'(5));
		runOp("afterAbortFinish", 1'b0, 1'b0, divWidth'(654321), divWidth'(17));

		for (int i = 0; i < numRandom; i++) begin
			rx = lcgNext();
			ry = lcgNext();
			if (i < numRandom / 2) begin
				runOp("randUnsigned", 1'b0, 1'b0, rx[31:4], ry[31:4] >> ry[3:0]);
			end else begin
				runOp("randMixed", ry[1], ry[2], rx[31:4], ry[31:4] >> ry[3:0]);
			end
		end

		// let the last latency check run out
		repeat (4) @(posedge clk);
		$display("errors: value %0d, timing %0d, abort %0d, reset %0d",
			valueErrs, timingErrs, abortErrs, resetErrs);
		if (valueErrs + timingErrs + abortErrs + resetErrs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : divUnitTb

`default_nettype wire

//--- flist.f
divCfgPkg.sv
divTypesPkg.sv
divCtrl.sv
divOperandPrep.sv
divCore.sv
divResultFix.sv
divUnit.sv
divUnitTb.sv

//--- Bender.yml
package:
  name: divUnit

sources:
  - files:
      - divCfgPkg.sv
      - divTypesPkg.sv
      - divCtrl.sv
      - divOperandPrep.sv
      - divCore.sv
      - divResultFix.sv
      - divUnit.sv
  - target: test
    files:
      - divUnitTb.sv
